/* Makefile */
# Verilator build and run of the pooling core testbench

SRCS := $(wildcard hdl/*.sv) $(wildcard verif/*.sv)

.PHONY: run clean

obj_dir/Vpool_tb: vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module pool_tb -f vlog.f

run: obj_dir/Vpool_tb
	./obj_dir/Vpool_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/map_fetch.sv */
// ==============================
// Map read address generator
// ==============================
`timescale 1ns/10ps

module map_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                busy,
    input  pool_pkg::pool_cfg_t cur_cfg,
    input  logic                free,
    input  logic                map_rd_addr_rdy,
    output logic                map_rd_addr_vld,
    output pool_pkg::idx_t      map_rd_addr,
    output logic                map_last,
    output logic                word_last
);
    import pool_pkg::*;

    logic [map_word_width-1:0] word_cnt;
    idx_t                      pnt_cnt;
    logic                      fin;
    logic                      addr_hs;
    logic                      word_end;
    logic                      pnt_end;

    assign word_end = word_cnt == map_word_width'(map_words - 1);
    assign pnt_end  = pnt_cnt == cur_cfg.nip - 16'd1;

    // A point starts only on a free gatherer, its later words follow freely
    assign map_rd_addr_vld = busy && !fin && (word_cnt != '0 || free);
    assign addr_hs         = map_rd_addr_vld && map_rd_addr_rdy;

    assign map_rd_addr = cur_cfg.map_rd_base + idx_t'(pnt_cnt * map_words)
                         + idx_t'(word_cnt);

    // Final word of a point, and of the whole run
    assign word_last = addr_hs && word_end;
    assign map_last  = word_last && pnt_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            pnt_cnt  <= '0;
            fin      <= 1'b0;
        end else if (!busy) begin
            word_cnt <= '0;
            pnt_cnt  <= '0;
            fin      <= 1'b0;
        end else if (addr_hs) begin
            word_cnt <= word_end ? '0 : word_cnt + 1'b1;
            if (word_end) begin
                pnt_cnt <= pnt_cnt + 16'd1;
                fin     <= pnt_end;
            end
        end
    end

endmodule

/* hdl/map_gather.sv */
// ==============================
// Map word gatherer
// ==============================
`timescale 1ns/10ps

module map_gather (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          busy,
    input  logic                          word_last,
    input  logic                          map_rd_dat_vld,
    input  logic [pool_pkg::sram_width-1:0] map_rd_dat,
    input  logic                          map_take,
    output logic                          map_rd_dat_rdy,
    output logic                          map_vld,
    output pool_pkg::map_arr_t            map_dat,
    output logic                          free
);
    import pool_pkg::*;

    logic [map_word_width-1:0] wcnt;
    logic                      pnt_pend;
    logic                      dat_hs;
    logic                      dat_end;

    // Stray data is dropped while idle, a held point blocks new words
    assign map_rd_dat_rdy = !busy || !map_vld;
    assign dat_hs         = busy && map_rd_dat_vld && !map_vld;
    assign dat_end        = wcnt == map_word_width'(map_words - 1);

    assign free = !pnt_pend && !map_vld && wcnt == '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wcnt     <= '0;
            pnt_pend <= 1'b0;
            map_vld  <= 1'b0;
        end else if (!busy) begin
            wcnt     <= '0;
            pnt_pend <= 1'b0;
            map_vld  <= 1'b0;
        end else begin
            // Last address out, its data still to come
            if (word_last) begin
                pnt_pend <= 1'b1;
            end else if (dat_hs && dat_end) begin
                pnt_pend <= 1'b0;
            end
            if (dat_hs) begin
                wcnt <= dat_end ? '0 : wcnt + 1'b1;
            end
            if (dat_hs && dat_end) begin
                map_vld <= 1'b1;
            end else if (map_take) begin
                map_vld <= 1'b0;
            end
        end
    end

    // Newest word enters at the top, so word 0 ends up lowest
    always_ff @(posedge clk) begin
        if (dat_hs) begin
            map_dat <= {map_rd_dat, map_dat[map_len-1:idx_per_word]};
        end
    end

endmodule

/* hdl/max_reduce.sv */
// ==============================
// Lane-wise max over K feature words
// and the output write port
// ==============================
`timescale 1ns/10ps

module max_reduce #(
    parameter int lanes = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   busy,
    input  pool_pkg::pool_cfg_t                    cur_cfg,
    input  logic                                   ofm_rd_dat_vld,
    input  logic [lanes*pool_pkg::act_width-1:0]   ofm_rd_dat,
    input  logic                                   ofm_wr_rdy,
    output logic                                   ofm_rd_dat_rdy,
    output logic                                   ofm_wr_vld,
    output logic [pool_pkg::idx_width+lanes*pool_pkg::act_width-1:0] ofm_wr,
    output logic                                   done
);
    import pool_pkg::*;

    typedef logic [lanes-1:0][act_width-1:0] vec_t;

    // Write beat, address above data
    typedef struct packed {
        idx_t addr;
        vec_t dat;
    } wr_beat_t;

    vec_t                 rd_vec;
    vec_t                 acc;
    vec_t                 acc_nxt;
    wr_beat_t             beat;
    logic                 acc_full;
    logic [map_width-1:0] nb_cnt;
    logic [map_width-1:0] nb_last;
    idx_t                 res_cnt;
    idx_t                 wr_cnt;
    idx_t                 res_last;
    logic                 rd_hs;
    logic                 wr_hs;
    logic                 load;

    assign rd_vec   = ofm_rd_dat;
    assign nb_last  = map_width'(cur_cfg.k - 8'd1);
    assign res_last = idx_t'(cur_cfg.nip * (cur_cfg.chn / lanes)) - 16'd1;

    // Input stalls only while a finished result waits behind the write port
    assign ofm_rd_dat_rdy = !busy || !acc_full;
    assign rd_hs          = busy && ofm_rd_dat_vld && !acc_full;
    assign wr_hs          = ofm_wr_vld && ofm_wr_rdy;
    assign load           = acc_full && (!ofm_wr_vld || ofm_wr_rdy);

    assign ofm_wr = beat;
    assign done   = wr_hs && wr_cnt == res_last;

    // First word of a group loads, later words keep the unsigned max
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            if (nb_cnt == '0 || rd_vec[i] > acc[i]) begin
                acc_nxt[i] = rd_vec[i];
            end else begin
                acc_nxt[i] = acc[i];
            end
        end
    end

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nb_cnt     <= '0;
            acc_full   <= 1'b0;
            ofm_wr_vld <= 1'b0;
            res_cnt    <= '0;
            wr_cnt     <= '0;
        end else if (!busy) begin
            nb_cnt     <= '0;
            acc_full   <= 1'b0;
            ofm_wr_vld <= 1'b0;
            res_cnt    <= '0;
            wr_cnt     <= '0;
        end else begin
            if (rd_hs) begin
                nb_cnt <= (nb_cnt == nb_last) ? '0 : nb_cnt + 1'b1;
            end
            if (rd_hs && nb_cnt == nb_last) begin
                acc_full <= 1'b1;
            end else if (load) begin
                acc_full <= 1'b0;
            end
            // Result moves into the write beat
            if (load) begin
                ofm_wr_vld <= 1'b1;
                res_cnt    <= res_cnt + 16'd1;
            end else if (wr_hs) begin
                ofm_wr_vld <= 1'b0;
            end
            if (wr_hs) begin
                wr_cnt <= wr_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            acc <= acc_nxt;
        end
        if (load) begin
            beat.addr <= cur_cfg.ofm_wr_base + res_cnt;
            beat.dat  <= acc;
        end
    end

endmodule

/* hdl/ofm_fetch.sv */
// ==============================
// Feature read address generator
// ==============================
`timescale 1ns/10ps

module ofm_fetch #(
    parameter int lanes = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                busy,
    input  pool_pkg::pool_cfg_t cur_cfg,
    input  logic                map_vld,
    input  pool_pkg::map_arr_t  map_dat,
    input  logic                ofm_rd_addr_rdy,
    output logic                ofm_rd_addr_vld,
    output pool_pkg::idx_t      ofm_rd_addr,
    output logic                map_take
);
    import pool_pkg::*;

    logic [map_width-1:0] nb_cnt;
    logic [chn_width-1:0] grp_cnt;
    logic [map_width-1:0] nb_last;
    logic [chn_width-1:0] grp_num;
    logic                 addr_hs;
    logic                 nb_end;
    logic                 grp_end;

    // ==============================
    // Loop bounds
    // ==============================
    assign nb_last = map_width'(cur_cfg.k - 8'd1);
    assign grp_num = chn_width'(cur_cfg.chn / lanes);
    assign nb_end  = nb_cnt == nb_last;
    assign grp_end = grp_cnt == grp_num - 1'b1;

    // ==============================
    // Address issue
    // ==============================
    assign ofm_rd_addr_vld = busy && map_vld;
    assign addr_hs         = ofm_rd_addr_vld && ofm_rd_addr_rdy;

    // Feature rows are grp_num words long
    assign ofm_rd_addr = cur_cfg.ofm_rd_base + idx_t'(map_dat[nb_cnt] * grp_num)
                         + idx_t'(grp_cnt);

    // Point fully read, release the neighbor array
    assign map_take = addr_hs && nb_end && grp_end;

    // Neighbor inner loop, channel group outer loop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else if (!busy) begin
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else if (addr_hs) begin
            if (nb_end) begin
                nb_cnt  <= '0;
                grp_cnt <= grp_end ? '0 : grp_cnt + 1'b1;
            end else begin
                nb_cnt <= nb_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/pool_ctrl.sv */
// ==============================
// Configuration accept and busy FSM
// ==============================
`timescale 1ns/10ps

module pool_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld,
    input  pool_pkg::pool_cfg_t cfg,
    input  logic                map_last,
    input  logic                done,
    output logic                cfg_rdy,
    output logic                busy,
    output pool_pkg::pool_cfg_t cur_cfg
);

    localparam logic [1:0] st_idle        = 2'd0;
    localparam logic [1:0] st_map_in      = 2'd1;
    localparam logic [1:0] st_wait_finish = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;

    assign cfg_rdy = state == st_idle;
    assign busy    = state != st_idle;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cfg_vld) begin
                    state_nxt = st_map_in;
                end
            end
            // Map addresses still being issued
            st_map_in: begin
                if (map_last) begin
                    state_nxt = st_wait_finish;
                end
            end
            // Drain features and writes
            st_wait_finish: begin
                if (done) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Held for the whole run
    always_ff @(posedge clk) begin
        if (cfg_vld && cfg_rdy) begin
            cur_cfg <= cfg;
        end
    end

endmodule

/* hdl/pool_pkg.sv */
// ==============================
// Widths, derived sizes and shared
// types of the pooling core
// ==============================
package pool_pkg;

    // ==============================
    // Base widths
    // ==============================
    parameter int idx_width  = 16;
    parameter int act_width  = 8;
    parameter int map_width  = 4;
    parameter int sram_width = 64;
    parameter int chn_width  = 12;

    // Derived from the widths above
    parameter int map_len        = 2 ** map_width;
    parameter int idx_per_word   = sram_width / idx_width;
    parameter int map_words      = map_len / idx_per_word;
    parameter int map_word_width = $clog2(map_words);

    // ==============================
    // Types
    // ==============================
    // Address or neighbor index
    typedef logic [idx_width-1:0] idx_t;

    // Neighbor list of one point, entry 0 in the low bits
    typedef idx_t [map_len-1:0] map_arr_t;

    // Configuration word, 84 bits
    typedef struct packed {
        logic [idx_width-1:0] nip;
        logic [7:0]           k;
        logic [chn_width-1:0] chn;
        idx_t                 map_rd_base;
        idx_t                 ofm_rd_base;
        idx_t                 ofm_wr_base;
    } pool_cfg_t;

endpackage

/* hdl/pool_top.sv */
// ==============================
// Pooling core top level
// ==============================
`timescale 1ns/10ps

module pool_top #(
    parameter int lanes = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Configuration
    input  logic                                   cfg_vld,
    output logic                                   cfg_rdy,
    input  pool_pkg::pool_cfg_t                    cfg,

    // Map memory
    output logic                                   map_rd_addr_vld,
    output pool_pkg::idx_t                         map_rd_addr,
    input  logic                                   map_rd_addr_rdy,
    input  logic                                   map_rd_dat_vld,
    input  logic [pool_pkg::sram_width-1:0]        map_rd_dat,
    output logic                                   map_rd_dat_rdy,

    // Feature memory
    output logic                                   ofm_rd_addr_vld,
    output pool_pkg::idx_t                         ofm_rd_addr,
    input  logic                                   ofm_rd_addr_rdy,
    input  logic                                   ofm_rd_dat_vld,
    input  logic [lanes*pool_pkg::act_width-1:0]   ofm_rd_dat,
    output logic                                   ofm_rd_dat_rdy,
    output logic                                   ofm_wr_vld,
    input  logic                                   ofm_wr_rdy,
    output logic [pool_pkg::idx_width+lanes*pool_pkg::act_width-1:0] ofm_wr
);
    import pool_pkg::*;

    logic      busy;
    pool_cfg_t cur_cfg;
    logic      map_last;
    logic      word_last;
    logic      free;
    logic      map_vld;
    map_arr_t  map_dat;
    logic      map_take;
    logic      done;

    pool_ctrl ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg      (cfg),
        .map_last (map_last),
        .done     (done),
        .cfg_rdy  (cfg_rdy),
        .busy     (busy),
        .cur_cfg  (cur_cfg)
    );

    map_fetch map_fetch_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .busy            (busy),
        .cur_cfg         (cur_cfg),
        .free            (free),
        .map_rd_addr_rdy (map_rd_addr_rdy),
        .map_rd_addr_vld (map_rd_addr_vld),
        .map_rd_addr     (map_rd_addr),
        .map_last        (map_last),
        .word_last       (word_last)
    );

    map_gather map_gather_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .busy           (busy),
        .word_last      (word_last),
        .map_rd_dat_vld (map_rd_dat_vld),
        .map_rd_dat     (map_rd_dat),
        .map_take       (map_take),
        .map_rd_dat_rdy (map_rd_dat_rdy),
        .map_vld        (map_vld),
        .map_dat        (map_dat),
        .free           (free)
    );

    ofm_fetch #(
        .lanes (lanes)
    ) ofm_fetch_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .busy            (busy),
        .cur_cfg         (cur_cfg),
        .map_vld         (map_vld),
        .map_dat         (map_dat),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy),
        .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr     (ofm_rd_addr),
        .map_take        (map_take)
    );

    max_reduce #(
        .lanes (lanes)
    ) max_reduce_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .busy           (busy),
        .cur_cfg        (cur_cfg),
        .ofm_rd_dat_vld (ofm_rd_dat_vld),
        .ofm_rd_dat     (ofm_rd_dat),
        .ofm_wr_rdy     (ofm_wr_rdy),
        .ofm_rd_dat_rdy (ofm_rd_dat_rdy),
        .ofm_wr_vld     (ofm_wr_vld),
        .ofm_wr         (ofm_wr),
        .done           (done)
    );

endmodule

/* verif/pool_tb.sv */
// ==============================
// Pooling core testbench with a config table,
// memory models, reference model and checks
// ==============================
`timescale 1ns/10ps

module pool_tb;
    import pool_pkg::*;

    localparam int lanes = 8;
    localparam int n_cfg = 6;

    typedef logic [lanes-1:0][act_width-1:0] vec_t;

    // Same layout as the write beat of the DUT
    typedef struct packed {
        idx_t addr;
        vec_t dat;
    } wr_beat_t;

    // Configuration with the number of writes it must produce
    typedef struct packed {
        pool_cfg_t cfg;
        idx_t      n_wr;
    } tbl_entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_vld;
    logic                  cfg_rdy;
    pool_cfg_t             cfg;
    logic                  map_rd_addr_vld;
    idx_t                  map_rd_addr;
    logic                  map_rd_addr_rdy = 1'b0;
    logic                  map_rd_dat_vld = 1'b0;
    logic [sram_width-1:0] map_rd_dat = '0;
    logic                  map_rd_dat_rdy;
    logic                  ofm_rd_addr_vld;
    idx_t                  ofm_rd_addr;
    logic                  ofm_rd_addr_rdy = 1'b0;
    logic                  ofm_rd_dat_vld = 1'b0;
    vec_t                  ofm_rd_dat = '0;
    logic                  ofm_rd_dat_rdy;
    logic                  ofm_wr_vld;
    logic                  ofm_wr_rdy = 1'b0;
    logic [idx_width+lanes*act_width-1:0] ofm_wr;

    logic [sram_width-1:0] map_mem [0:4095];
    vec_t                  feat_mem [0:4095];
    tbl_entry_t            tbl [0:n_cfg-1];

    // Expected traffic from the reference model
    idx_t     exp_map_q[$];
    idx_t     exp_ofm_q[$];
    wr_beat_t exp_wr_q[$];
    // Reads in flight inside the memory models
    idx_t     map_pend_q[$];
    int       map_due_q[$];
    idx_t     ofm_pend_q[$];
    int       ofm_due_q[$];

    integer seed = 95551;
    int     cycle = 0;
    int     limit = 0;
    int     last_wr_cycle = 0;
    int     wr_total = 0;
    int     check_cnt = 0;
    int     mismatch_cnt = 0;
    int     other_cnt = 0;
    logic   stall = 1'b0;

    pool_top #(
        .lanes (lanes)
    ) dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg             (cfg),
        .map_rd_addr_vld (map_rd_addr_vld),
        .map_rd_addr     (map_rd_addr),
        .map_rd_addr_rdy (map_rd_addr_rdy),
        .map_rd_dat_vld  (map_rd_dat_vld),
        .map_rd_dat      (map_rd_dat),
        .map_rd_dat_rdy  (map_rd_dat_rdy),
        .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr     (ofm_rd_addr),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy),
        .ofm_rd_dat_vld  (ofm_rd_dat_vld),
        .ofm_rd_dat      (ofm_rd_dat),
        .ofm_rd_dat_rdy  (ofm_rd_dat_rdy),
        .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_rdy      (ofm_wr_rdy),
        .ofm_wr          (ofm_wr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_idx(input string what, input idx_t got, input idx_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_wr(input wr_beat_t got, input wr_beat_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: write got addr %h data %h, expected addr %h data %h",
                     $time, got.addr, got.dat, exp.addr, exp.dat);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ==============================
    // Reference model
    // ==============================
    // Neighbor j of point p
    function automatic idx_t nbr(input int p, input int j);
        return idx_t'((p * 5 + j * 3) % 32);
    endfunction

    function automatic tbl_entry_t make_entry(input int nip, input int k, input int chn,
                                              input int map_base, input int rd_base,
                                              input int wr_base, input int n_wr);
        tbl_entry_t e;
        e.cfg.nip         = idx_t'(nip);
        e.cfg.k           = 8'(k);
        e.cfg.chn         = chn_width'(chn);
        e.cfg.map_rd_base = idx_t'(map_base);
        e.cfg.ofm_rd_base = idx_t'(rd_base);
        e.cfg.ofm_wr_base = idx_t'(wr_base);
        e.n_wr            = idx_t'(n_wr);
        return e;
    endfunction

    task automatic load_table();
        //                  nip  k  chn  map base  rd base   wr base  writes
        tbl[0] = make_entry(1,   1,  8, 'h0010,   'h0100,   'h0800,   1);
        tbl[1] = make_entry(3,   7, 16, 'h0040,   'h0200,   'h0900,   6);
        tbl[2] = make_entry(5,  16, 32, 'h0080,   'h0300,   'h0a00,  20);
        tbl[3] = make_entry(2,  16,  8, 'h00c0,   'h0400,   'h0b00,   2);
        tbl[4] = make_entry(4,   1, 24, 'h0100,   'h0500,   'h0c00,  12);
        tbl[5] = make_entry(5,   7, 32, 'h0140,   'h0600,   'h0d00,  20);
    endtask

    // Allows 8 cycles per expected transfer over both passes of the table
    function automatic int budget();
        int sum;
        sum = 0;
        for (int c = 0; c < n_cfg; c++) begin
            sum += int'(tbl[c].cfg.nip) * (map_words + 2 * int'(tbl[c].cfg.k)
                   * (int'(tbl[c].cfg.chn) / lanes));
        end
        return 2 * sum * 8 + 200;
    endfunction

    task automatic fill_map(input pool_cfg_t c);
        idx_t a;
        for (int p = 0; p < int'(c.nip); p++) begin
            for (int w = 0; w < map_words; w++) begin
                a = c.map_rd_base + idx_t'(p * map_words + w);
                for (int i = 0; i < idx_per_word; i++) begin
                    map_mem[a[11:0]][i*idx_width +: idx_width] = nbr(p, w * idx_per_word + i);
                end
            end
        end
    endtask

    task automatic build_expect(input pool_cfg_t c);
        int       groups;
        idx_t     a;
        vec_t     word;
        wr_beat_t beat;
        groups = int'(c.chn) / lanes;
        for (int p = 0; p < int'(c.nip); p++) begin
            for (int w = 0; w < map_words; w++) begin
                exp_map_q.push_back(c.map_rd_base + idx_t'(p * map_words + w));
            end
            // Group outer, neighbor inner
            for (int g = 0; g < groups; g++) begin
                beat.addr = c.ofm_wr_base + idx_t'(p * groups + g);
                beat.dat  = '0;
                for (int j = 0; j < int'(c.k); j++) begin
                    a = c.ofm_rd_base + idx_t'(int'(nbr(p, j)) * groups + g);
                    exp_ofm_q.push_back(a);
                    word = feat_mem[a[11:0]];
                    for (int l = 0; l < lanes; l++) begin
                        if (j == 0 || word[l] > beat.dat[l]) begin
                            beat.dat[l] = word[l];
                        end
                    end
                end
                exp_wr_q.push_back(beat);
            end
        end
    endtask

    // ==============================
    // Memory models and ready generation
    // ==============================
    always @(posedge clk) begin : mem_model
        logic [31:0] rnd;
        idx_t        a;
        rnd = $random(seed);
        if (stall) begin
            map_rd_addr_rdy <= rnd[0];
            ofm_rd_addr_rdy <= rnd[1];
            ofm_wr_rdy      <= rnd[2];
        end else begin
            map_rd_addr_rdy <= 1'b1;
            ofm_rd_addr_rdy <= 1'b1;
            ofm_wr_rdy      <= 1'b1;
        end
        if (map_rd_addr_vld && map_rd_addr_rdy) begin
            map_pend_q.push_back(map_rd_addr);
            map_due_q.push_back(cycle + (stall ? int'(rnd[5:4]) : 0));
        end
        if (ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
            ofm_pend_q.push_back(ofm_rd_addr);
            ofm_due_q.push_back(cycle + (stall ? int'(rnd[7:6]) : 0));
        end
        // Data held until taken, then the next due word in order
        if (!map_rd_dat_vld || map_rd_dat_rdy) begin
            if (map_pend_q.size() > 0 && map_due_q[0] <= cycle) begin
                a = map_pend_q.pop_front();
                void'(map_due_q.pop_front());
                map_rd_dat_vld <= 1'b1;
                map_rd_dat     <= map_mem[a[11:0]];
            end else begin
                map_rd_dat_vld <= 1'b0;
            end
        end
        if (!ofm_rd_dat_vld || ofm_rd_dat_rdy) begin
            if (ofm_pend_q.size() > 0 && ofm_due_q[0] <= cycle) begin
                a = ofm_pend_q.pop_front();
                void'(ofm_due_q.pop_front());
                ofm_rd_dat_vld <= 1'b1;
                ofm_rd_dat     <= feat_mem[a[11:0]];
            end else begin
                ofm_rd_dat_vld <= 1'b0;
            end
        end
    end

    // Handshake monitor
    always @(posedge clk) begin
        if (map_rd_addr_vld && map_rd_addr_rdy) begin
            if (exp_map_q.size() == 0) begin
                other_cnt++;
                $display("Unexpected map read of address %h at %0t", map_rd_addr, $time);
            end else begin
                check_idx("map read address", map_rd_addr, exp_map_q.pop_front());
            end
        end
        if (ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
            if (exp_ofm_q.size() == 0) begin
                other_cnt++;
                $display("Unexpected feature read of address %h at %0t", ofm_rd_addr, $time);
            end else begin
                check_idx("feature read address", ofm_rd_addr, exp_ofm_q.pop_front());
            end
        end
        if (ofm_wr_vld && ofm_wr_rdy) begin
            wr_total++;
            last_wr_cycle = cycle;
            if (exp_wr_q.size() == 0) begin
                other_cnt++;
                $display("Unexpected write at %0t", $time);
            end else begin
                check_wr(wr_beat_t'(ofm_wr), exp_wr_q.pop_front());
            end
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("The run timed out after %0d cycles", cycle);
            $display("checks %0d, mismatches %0d, other errors %0d",
                     check_cnt, mismatch_cnt, other_cnt + 1);
            $display("Checks failed");
            $finish;
        end
    end

    // ==============================
    // Sequence
    // ==============================
    task automatic run_config(input int c);
        pool_cfg_t c_cfg;
        int        wr_start;
        c_cfg = tbl[c].cfg;
        fill_map(c_cfg);
        build_expect(c_cfg);
        wr_start = wr_total;
        cfg_vld <= 1'b1;
        cfg     <= c_cfg;
        @(posedge clk);
        check_bit("cfg_rdy at accept", cfg_rdy, 1'b1);
        check_bit("map address valid at accept", map_rd_addr_vld, 1'b0);
        cfg_vld <= 1'b0;
        @(posedge clk);
        check_bit("cfg_rdy while busy", cfg_rdy, 1'b0);
        check_bit("map address valid after accept", map_rd_addr_vld, 1'b1);
        while (!cfg_rdy) begin
            @(posedge clk);
        end
        check_idx("cycles from last write to cfg_rdy", idx_t'(cycle - last_wr_cycle), 16'd1);
        check_idx("write count", idx_t'(wr_total - wr_start), tbl[c].n_wr);
        if (exp_map_q.size() != 0 || exp_ofm_q.size() != 0 || exp_wr_q.size() != 0) begin
            other_cnt++;
            $display("Configuration %0d left %0d map reads, %0d feature reads, %0d writes",
                     c, exp_map_q.size(), exp_ofm_q.size(), exp_wr_q.size());
            exp_map_q.delete();
            exp_ofm_q.delete();
            exp_wr_q.delete();
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        cfg_vld = 1'b0;
        cfg     = '0;
        load_table();
        for (int i = 0; i < 4096; i++) begin
            feat_mem[i] = {$random(seed), $random(seed)};
        end
        limit = budget();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("cfg_rdy after reset", cfg_rdy, 1'b1);
        check_bit("map_rd_addr_vld after reset", map_rd_addr_vld, 1'b0);
        check_bit("ofm_rd_addr_vld after reset", ofm_rd_addr_vld, 1'b0);
        check_bit("ofm_wr_vld after reset", ofm_wr_vld, 1'b0);
        check_bit("map_rd_dat_rdy after reset", map_rd_dat_rdy, 1'b1);
        check_bit("ofm_rd_dat_rdy after reset", ofm_rd_dat_rdy, 1'b1);
        // First pass without stalls, second with random ready and latency
        for (int pass = 0; pass < 2; pass++) begin
            stall <= (pass == 1);
            for (int c = 0; c < n_cfg; c++) begin
                run_config(c);
            end
        end
        @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/pool_pkg.sv
hdl/pool_ctrl.sv
hdl/map_fetch.sv
hdl/map_gather.sv
hdl/ofm_fetch.sv
hdl/max_reduce.sv
hdl/pool_top.sv
verif/pool_tb.sv
